// File: build.f
+incdir+include
hw/retire_pkg.sv
hw/rec_fetch_stage.sv
hw/pipe_hold_stage.sv
hw/step_controller.sv
hw/pipeline_shell.sv
bench/tb_rec_mem.sv
bench/tb_pipeline_shell.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f build.f --top-module tb_pipeline_shell -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: bench/tb_pipeline_shell.sv
`timescale 1ns/1ps
`include "shell_defs.svh"

module tb_pipeline_shell;
    import retire_pkg::*;

    localparam int WORDS = 1 << `SHELL_ADR_W;

    logic        clk;
    logic        rst_n;
    logic        retire;
    logic        lsu_resp;
    wb_m2s_t     wb_m2s;
    wb_s2m_t     wb_s2m;
    logic        retire_valid;
    retire_rec_t retire_rec;
    logic        irq_allowed;

    logic [`SHELL_XLEN-1:0] rec_img [0:WORDS-1];
    integer      seed = 95840;
    int          err_mismatch = 0;
    int          err_other = 0;
    bit          timed_out = 1'b0;
    int          strobe_cnt = 0;
    int          pulse_cnt = 0;
    int          ack_cnt = 0;
    int          lsu_owed = 0;
    int          resp_sent = 0;
    int          exp_lsu = 0;
    logic        resp_at_edge = 1'b0;
    logic        prev_valid = 1'b0;
    bit          seen_irq_low = 1'b0;
    retire_rec_t last_rec;

    pipeline_shell u_dut (
        .clk            (clk         ),
        .rst_n          (rst_n       ),
        .retire_i       (retire      ),
        .lsu_resp_i     (lsu_resp    ),
        .wb_o           (wb_m2s      ),
        .wb_i           (wb_s2m      ),
        .retire_valid_o (retire_valid),
        .retire_rec_o   (retire_rec  ),
        .irq_allowed_o  (irq_allowed )
    );

    tb_rec_mem u_mem (
        .clk   (clk   ),
        .rst_n (rst_n ),
        .wb_i  (wb_m2s),
        .wb_o  (wb_s2m)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic is_mem_op(input insn_u w);
        return (w.r.opcode == OPC_LOAD) || (w.r.opcode == OPC_STORE);
    endfunction

    // Record k is the insn/pc pair at words 2k and 2k+1
    function automatic retire_rec_t ref_rec(input int k);
        retire_rec_t r;
        r.order    = `SHELL_ORDER_W'(k);
        r.insn.raw = rec_img[2*k];
        r.pc       = rec_img[2*k+1];
        return r;
    endfunction

    function automatic int lsu_count_next(input int cnt, input logic up, input logic resp);
        return cnt + int'(up) - int'(resp);
    endfunction

    task automatic check_rec(input string name, input retire_rec_t act, input retire_rec_t exp);
        if (act !== exp) begin
            err_mismatch++;
            $display("mismatch %s: got %h expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            err_mismatch++;
            $display("mismatch %s: got %h expected %h at %0t", name, act, exp, $time);
        end
    endtask

    ////////////////////
    // Monitors
    ////////////////////

    always @(posedge clk) begin : edge_sample
        resp_at_edge <= lsu_resp;
        if (rst_n && retire) begin
            strobe_cnt <= strobe_cnt + 1;
        end
    end

    always @(negedge clk) begin : ack_count
        if (rst_n && wb_s2m.ack) begin
            ack_cnt++;
        end
    end

    always @(negedge clk) begin : compare_proc
        retire_rec_t exp_rec;
        logic        up;
        if (rst_n) begin
            up = 1'b0;
            if (wb_m2s.cyc) begin
                check_bit("wb_o.we", wb_m2s.we, 1'b0);
            end
            if (retire_valid) begin
                if (prev_valid) begin
                    err_other++;
                    $display("retire_valid_o stayed high for a second cycle at %0t", $time);
                end
                if (pulse_cnt >= strobe_cnt) begin
                    err_other++;
                    $display("retire pulse arrived with no retire strobe waiting at %0t", $time);
                end
                exp_rec = ref_rec(pulse_cnt);
                check_rec("retire_rec_o", retire_rec, exp_rec);
                last_rec = exp_rec;
                up = is_mem_op(exp_rec.insn);
                if (up) begin
                    lsu_owed++;
                end
                pulse_cnt++;
            end else if (pulse_cnt > 0) begin
                // Record must hold between pulses
                check_rec("retire_rec_o", retire_rec, last_rec);
            end
            prev_valid = retire_valid;
            exp_lsu = lsu_count_next(exp_lsu, up, resp_at_edge);
            if (!retire_valid && pulse_cnt == strobe_cnt) begin
                check_bit("irq_allowed_o", irq_allowed, exp_lsu == 0);
                if (!irq_allowed) begin
                    seen_irq_low = 1'b1;
                end
            end
        end
    end

    // One memory response per retired load or store
    initial begin : lsu_responder
        forever begin
            @(posedge clk);
            if (resp_sent < lsu_owed) begin
                repeat (1 + resp_sent % 3) @(negedge clk);
                lsu_resp = 1'b1;
                @(negedge clk);
                lsu_resp = 1'b0;
                resp_sent++;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic report_timeout(input string what);
        err_other++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s at %0t", what, $time);
    endtask

    task automatic wait_acks(input int target, input int limit);
        int n;
        n = 0;
        while (!timed_out && ack_cnt < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!timed_out && ack_cnt < target) begin
            report_timeout("the first record reads");
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (!timed_out && pulse_cnt != strobe_cnt && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!timed_out && pulse_cnt != strobe_cnt) begin
            report_timeout("retire pulses");
        end
    endtask

    task automatic wait_lsu_settled(input int limit);
        int n;
        n = 0;
        while (!timed_out && resp_sent != lsu_owed && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!timed_out && resp_sent != lsu_owed) begin
            report_timeout("memory responses");
        end
    endtask

    task automatic pulse_retire(input int n);
        @(negedge clk);
        retire = 1'b1;
        repeat (n) @(negedge clk);
        retire = 1'b0;
    endtask

    initial begin : main_flow
        insn_u w;
        int    i;
        int    sel;
        clk      = 1'b0;
        rst_n    = 1'b0;
        retire   = 1'b0;
        lsu_resp = 1'b0;
        // About a third of the insn words are loads or stores
        for (i = 0; i < WORDS; i += 2) begin
            w.raw = $random(seed);
            sel   = {$random(seed)} % 6;
            if (sel == 0) begin
                w.r.opcode = OPC_LOAD;
            end else if (sel == 1) begin
                w.r.opcode = OPC_STORE;
            end else if (is_mem_op(w)) begin
                w.r.opcode = 7'b0110011;
            end
            rec_img[i]       = w.raw;
            rec_img[i+1]     = $random(seed);
            u_mem.mem[i]     = rec_img[i];
            u_mem.mem[i+1]   = rec_img[i+1];
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("retire_valid_o", retire_valid, 1'b0);
        check_bit("irq_allowed_o", irq_allowed, 1'b1);
        check_bit("wb_o.cyc", wb_m2s.cyc, 1'b0);
        check_bit("wb_o.stb", wb_m2s.stb, 1'b0);
        // Wait for two fill steps and the third record's prefetch
        wait_acks(6, 200);
        for (i = 0; i < 8; i++) begin
            pulse_retire(1);
            wait_drained(60);
            repeat (1 + i % 4) @(negedge clk);
        end
        for (i = 0; i < 4; i++) begin
            pulse_retire(3);
            wait_drained(120);
            repeat (3) @(negedge clk);
        end
        wait_lsu_settled(100);
        repeat (5) @(negedge clk);
        if (pulse_cnt != strobe_cnt) begin
            err_other++;
            $display("%0d retire pulses seen for %0d retire strobes", pulse_cnt, strobe_cnt);
        end
        check_bit("irq_allowed_o", irq_allowed, 1'b1);
        if (!seen_irq_low) begin
            err_other++;
            $display("irq_allowed_o never went low during the run");
        end
        $display("errors: %0d mismatch, %0d other; %0d strobes, %0d pulses",
                 err_mismatch, err_other, strobe_cnt, pulse_cnt);
        if (err_mismatch == 0 && err_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: bench/tb_rec_mem.sv
`timescale 1ns/1ps
`include "shell_defs.svh"

module tb_rec_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  retire_pkg::wb_m2s_t wb_i,
    output retire_pkg::wb_s2m_t wb_o
);
    import retire_pkg::*;

    localparam int WORDS = 1 << `SHELL_ADR_W;

    // Record words, filled by the testbench before reset ends
    logic [`SHELL_XLEN-1:0] mem [0:WORDS-1];

    integer                 seed = 95840;
    logic [1:0]             wait_q;
    logic                   ack_q;
    logic [`SHELL_XLEN-1:0] dat_q;

    ////////////////////
    // Classic slave
    ////////////////////

    // Ack comes 1 to 3 cycles after the strobe is seen
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 2'd0;
            ack_q  <= 1'b0;
            dat_q  <= '0;
        end else if (ack_q) begin
            ack_q  <= 1'b0;
            wait_q <= 2'({$random(seed)} % 3);
        end else if (wb_i.cyc && wb_i.stb) begin
            if (wait_q == 2'd0) begin
                ack_q <= 1'b1;
                dat_q <= mem[wb_i.adr];
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = dat_q;

endmodule

// File: hw/pipeline_shell.sv
`timescale 1ns/1ps

module pipeline_shell (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    retire_i,
    input  logic                    lsu_resp_i,
    output retire_pkg::wb_m2s_t     wb_o,
    input  retire_pkg::wb_s2m_t     wb_i,
    output logic                    retire_valid_o,
    output retire_pkg::retire_rec_t retire_rec_o,
    output logic                    irq_allowed_o
);
    import retire_pkg::*;

    pipe_stage_t if_pipe;
    pipe_stage_t id_pipe;
    pipe_stage_t ex_pipe;
    logic        step;
    logic        fetch_ready;

    ////////////////////
    // Stages
    ////////////////////

    rec_fetch_stage u_fetch (
        .clk           (clk        ),
        .rst_n         (rst_n      ),
        .step_i        (step       ),
        .wb_o          (wb_o       ),
        .wb_i          (wb_i       ),
        .fetch_ready_o (fetch_ready),
        .pipe_o        (if_pipe    )
    );

    // Decode keeps valid, execute turns it into a retire pulse
    pipe_hold_stage #(.PULSE_VALID(1'b0)) u_id (
        .clk    (clk    ),
        .rst_n  (rst_n  ),
        .step_i (step   ),
        .pipe_i (if_pipe),
        .pipe_o (id_pipe)
    );

    pipe_hold_stage #(.PULSE_VALID(1'b1)) u_ex (
        .clk    (clk    ),
        .rst_n  (rst_n  ),
        .step_i (step   ),
        .pipe_i (id_pipe),
        .pipe_o (ex_pipe)
    );

    step_controller u_ctrl (
        .clk           (clk          ),
        .rst_n         (rst_n        ),
        .retire_i      (retire_i     ),
        .lsu_resp_i    (lsu_resp_i   ),
        .fetch_ready_i (fetch_ready  ),
        .id_pipe_i     (id_pipe      ),
        .step_o        (step         ),
        .irq_allowed_o (irq_allowed_o)
    );

    // Writeback is just the execute register
    assign retire_valid_o = ex_pipe.valid;
    assign retire_rec_o   = ex_pipe.rec;

endmodule

// File: hw/step_controller.sv
`timescale 1ns/1ps
`include "shell_defs.svh"

module step_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    retire_i,
    input  logic                    lsu_resp_i,
    input  logic                    fetch_ready_i,
    input  retire_pkg::pipe_stage_t id_pipe_i,
    output logic                    step_o,
    output logic                    irq_allowed_o
);
    import retire_pkg::*;

    localparam int PEND_W = $clog2(`SHELL_PEND_DEPTH + 1);
    localparam int LSU_W  = $clog2(`SHELL_LSU_DEPTH + 1);

    localparam logic [PEND_W-1:0] PEND_MAX = PEND_W'(`SHELL_PEND_DEPTH);
    localparam logic [LSU_W-1:0]  LSU_MAX  = LSU_W'(`SHELL_LSU_DEPTH);

    logic [1:0]        fill_cnt_q;
    logic              filling;
    logic              served;
    logic [PEND_W-1:0] pend_q;
    logic [PEND_W-1:0] pend_d;
    logic              mem_in_ex;
    logic              lsu_up;
    logic [LSU_W-1:0]  lsu_cnt_q;
    logic [LSU_W-1:0]  lsu_cnt_d;

    ////////////////////
    // Step generation
    ////////////////////

    // Two fill steps line the stages up with the core
    assign filling = (fill_cnt_q != 2'd2);

    assign step_o = fetch_ready_i && (filling || (pend_q != '0) || retire_i);
    assign served = step_o && !filling;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt_q <= 2'd0;
        end else if (step_o && filling) begin
            fill_cnt_q <= fill_cnt_q + 2'd1;
        end
    end

    // Retire strobes still waiting for a step
    always_comb begin
        pend_d = pend_q;
        if (retire_i && !served && pend_q != PEND_MAX) begin
            pend_d = pend_q + 1'b1;
        end else if (!retire_i && served) begin
            pend_d = pend_q - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= '0;
        end else begin
            pend_q <= pend_d;
        end
    end

    ////////////////////
    // Outstanding LSU
    ////////////////////

    // Load or store about to move into execute
    assign mem_in_ex = id_pipe_i.valid &&
                       ((id_pipe_i.rec.insn.r.opcode == OPC_LOAD) ||
                        (id_pipe_i.rec.insn.r.opcode == OPC_STORE));
    assign lsu_up    = step_o && mem_in_ex;

    always_comb begin
        case ({lsu_up, lsu_resp_i})
            2'b10:   lsu_cnt_d = lsu_cnt_q + 1'b1;
            2'b01:   lsu_cnt_d = lsu_cnt_q - 1'b1;
            default: lsu_cnt_d = lsu_cnt_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsu_cnt_q <= '0;
        end else begin
            lsu_cnt_q <= lsu_cnt_d;
        end
    end

    // No debug, fence or sleep terms here, LSU only
    assign irq_allowed_o = (lsu_cnt_q == '0);

    ////////////////////
    // Checks
    ////////////////////

    a_lsu_depth: assert property (@(posedge clk) disable iff (!rst_n)
        (lsu_up && !lsu_resp_i) |-> (lsu_cnt_q < LSU_MAX))
        else $error("outstanding LSU count above depth");

    a_lsu_resp: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_resp_i |-> (lsu_cnt_q != '0))
        else $error("LSU response with nothing outstanding");

    a_pend_ovf: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_i && !served) |-> (pend_q < PEND_MAX))
        else $error("pending retire count overflow");

endmodule

// File: hw/pipe_hold_stage.sv
`timescale 1ns/1ps

module pipe_hold_stage #(
    parameter bit PULSE_VALID = 1'b0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    step_i,
    input  retire_pkg::pipe_stage_t pipe_i,
    output retire_pkg::pipe_stage_t pipe_o
);
    import retire_pkg::*;

    retire_rec_t rec_q;
    logic        valid_q;

    ////////////////////
    // Valid flag
    ////////////////////

    // Pulse mode keeps valid for the step cycle only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (step_i) begin
            valid_q <= pipe_i.valid;
        end else if (PULSE_VALID) begin
            valid_q <= 1'b0;
        end
    end

    ////////////////////
    // Record payload
    ////////////////////

    // Record stays between steps in both modes
    always_ff @(posedge clk) begin
        if (step_i) begin
            rec_q <= pipe_i.rec;
        end
    end

    assign pipe_o.rec   = rec_q;
    assign pipe_o.valid = valid_q;

endmodule

// File: hw/rec_fetch_stage.sv
`timescale 1ns/1ps
`include "shell_defs.svh"

module rec_fetch_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    step_i,
    output retire_pkg::wb_m2s_t     wb_o,
    input  retire_pkg::wb_s2m_t     wb_i,
    output logic                    fetch_ready_o,
    output retire_pkg::pipe_stage_t pipe_o
);
    import retire_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_INSN,
        S_GAP,
        S_RD_PC,
        S_FULL
    } fetch_state_e;

    fetch_state_e              state_q;
    fetch_state_e              state_d;
    logic [`SHELL_ADR_W-1:0]   adr_q;
    logic [`SHELL_ORDER_W-1:0] order_q;
    insn_u                     insn_buf;
    logic [`SHELL_XLEN-1:0]    pc_buf;
    retire_rec_t               rec_q;
    logic                      valid_q;
    logic                      bus_active;
    logic                      bus_done;

    ////////////////////
    // Read sequencer
    ////////////////////

    // Insn read, idle gap, pc read, then wait for a step
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    state_d = S_RD_INSN;
            S_RD_INSN: if (wb_i.ack) state_d = S_GAP;
            S_GAP:     state_d = S_RD_PC;
            S_RD_PC:   if (wb_i.ack) state_d = S_FULL;
            S_FULL:    if (step_i) state_d = S_RD_INSN;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            adr_q   <= '0;
        end else begin
            state_q <= state_d;
            // Word address walks through insn/pc pairs
            if (bus_done) begin
                adr_q <= adr_q + 1'b1;
            end
        end
    end

    assign bus_active    = (state_q == S_RD_INSN) || (state_q == S_RD_PC);
    assign bus_done      = bus_active && wb_i.ack;
    assign fetch_ready_o = (state_q == S_FULL);

    // Bus lines follow the state and stay put until ack
    assign wb_o.cyc = bus_active;
    assign wb_o.stb = bus_active;
    assign wb_o.we  = 1'b0;
    assign wb_o.adr = adr_q;

    // Prefetch buffer
    always_ff @(posedge clk) begin
        if (bus_done && state_q == S_RD_INSN) begin
            insn_buf.raw <= wb_i.dat;
        end
        if (bus_done && state_q == S_RD_PC) begin
            pc_buf <= wb_i.dat;
        end
    end

    ////////////////////
    // Fetch register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            order_q <= '0;
            valid_q <= 1'b0;
        end else if (step_i) begin
            order_q <= order_q + 1'b1;
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (step_i) begin
            rec_q.order <= order_q;
            rec_q.pc    <= pc_buf;
            rec_q.insn  <= insn_buf;
        end
    end

    assign pipe_o.rec   = rec_q;
    assign pipe_o.valid = valid_q;

    // Strobe stays up until the slave acks
    a_stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_o.stb && !wb_i.ack) |=> wb_o.stb)
        else $error("stb dropped before ack");

endmodule

// File: hw/retire_pkg.sv
`include "shell_defs.svh"

package retire_pkg;

    // Major opcodes of loads and stores
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // R-type field view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } insn_r_t;

    // Same word, seen raw or split into fields
    typedef union packed {
        logic [`SHELL_XLEN-1:0] raw;
        insn_r_t                r;
    } insn_u;

    // One retirement record, 80 bits
    typedef struct packed {
        logic [`SHELL_ORDER_W-1:0] order;
        logic [`SHELL_XLEN-1:0]    pc;
        insn_u                     insn;
    } retire_rec_t;

    // Stage register contents
    typedef struct packed {
        retire_rec_t rec;
        logic        valid;
    } pipe_stage_t;

    // Wishbone classic, master to slave (read only)
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`SHELL_ADR_W-1:0] adr;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic                   ack;
        logic [`SHELL_XLEN-1:0] dat;
    } wb_s2m_t;

endpackage

// File: include/shell_defs.svh
`ifndef SHELL_DEFS_SVH
`define SHELL_DEFS_SVH

////////////////////
// Data path widths
////////////////////

// Instruction and pc word width
`define SHELL_XLEN 32

// Retirement order counter width
`define SHELL_ORDER_W 16

// Word address width of the record memory
`define SHELL_ADR_W 10

////////////////////
// Controller depths
////////////////////

// Memory operations that may be outstanding at once
`define SHELL_LSU_DEPTH 2

// Retire strobes that may wait for a step
`define SHELL_PEND_DEPTH 3

`endif
